// File: crossbar.f
+incdir+src
src/crossbar_pkg.sv
src/crossbar_queue_if.sv
src/crossbar_in_queue.sv
src/crossbar_arbiter.sv
src/crossbar_switch.sv
src/crossbar.sv
verif/crossbar_properties.sv
verif/crossbar_tb.sv

// File: Bender.yml
package:
  name: crossbar

sources:
  - include_dirs:
      - src
    files:
      - src/crossbar_pkg.sv
      - src/crossbar_queue_if.sv
      - src/crossbar_in_queue.sv
      - src/crossbar_arbiter.sv
      - src/crossbar_switch.sv
      - src/crossbar.sv
  - target: test
    include_dirs:
      - src
    files:
      - verif/crossbar_properties.sv
      - verif/crossbar_tb.sv

// File: verif/crossbar_tests.txt
# V test mask ctl0 data0 ctl1 data1 ctl2 data2 ctl3 data3  (one cycle, mask and cells in hex)
# E test delivered_count  |  R test random_cycles  (decimal)
# single cell, input 0 to output 1
V 2 1 51 cafe0001 00 00000000 00 00000000 00 00000000
E 2 1
# four distinct destinations at once
V 3 f 13 00000301 22 00000302 31 00000303 40 00000304
E 3 4
# inputs 0..2 all to output 3, input 1 then queues a cell for output 0
V 4 7 a3 00000401 b3 00000402 c3 00000403 00 00000000
V 4 2 00 00000000 d0 00000404 00 00000000 00 00000000
E 4 4
# input 0 keeps output 2 busy while input 1 overfills its queue
V 5 3 02 00000501 12 00000511 00 00000000 00 00000000
V 5 3 06 00000502 16 00000512 00 00000000 00 00000000
V 5 3 0a 00000503 1a 00000513 00 00000000 00 00000000
V 5 3 0e 00000504 1e 00000514 00 00000000 00 00000000
V 5 3 22 00000505 32 00000515 00 00000000 00 00000000
V 5 3 26 00000506 36 00000516 00 00000000 00 00000000
E 5 10
# every input bursts to output 0, queues wrap
V 6 f 60 00000601 64 00000611 68 00000621 6c 00000631
V 6 f 70 00000602 74 00000612 78 00000622 7c 00000632
V 6 f 80 00000603 84 00000613 88 00000623 8c 00000633
E 6 12
# random traffic
R 7 300

// File: verif/crossbar_tb.sv
`timescale 1ns/1ps
`include "crossbar_config.svh"

module crossbar_tb;

	localparam int PORTS = `XBAR_PORTS;
	localparam int DEPTH = `XBAR_QUEUE_DEPTH;
	localparam int CELL_W = $bits(crossbar_pkg::cell_t);
	localparam string TEST_FILE = "verif/crossbar_tests.txt";

	logic clk;
	logic rst;
	logic [PORTS-1:0] in_valid;
	logic [`XBAR_CTL_W-1:0] in_ctl [PORTS];
	logic [`XBAR_DATA_W-1:0] in_data [PORTS];
	wire [PORTS-1:0] in_full;
	wire [PORTS-1:0] out_wr;
	wire [`XBAR_CTL_W-1:0] out_ctl [PORTS];
	wire [`XBAR_DATA_W-1:0] out_data [PORTS];

	// reference model state
	crossbar_pkg::cell_t model_q [PORTS][$];
	crossbar_pkg::cell_t exp_cell [PORTS];
	logic [PORTS-1:0] exp_wr;

	// records loaded from the vector file
	byte rec_kind [$];
	int rec_test [$];
	int rec_arg [$];
	logic [PORTS-1:0] rec_mask [$];
	logic [PORTS*CELL_W-1:0] rec_cells [$];

	int vec_lines = 0;
	int rand_cycles = 0;
	int n_tests = 0;
	int delivered = 0;
	int accepted = 0;
	int test_errors = 0;
	int tests_passed = 0;
	int tests_failed = 0;
	longint watch_limit = 0;
	logic [31:0] rand_state = 32'h14f9_c97e;
	logic [3:0] seq_num [PORTS];
	bit loaded;

	crossbar dut0 (
		.clk(clk),
		.rst(rst),
		.in_valid0(in_valid[0]), .in_ctl0(in_ctl[0]), .in_data0(in_data[0]), .in_full0(in_full[0]),
		.in_valid1(in_valid[1]), .in_ctl1(in_ctl[1]), .in_data1(in_data[1]), .in_full1(in_full[1]),
		.in_valid2(in_valid[2]), .in_ctl2(in_ctl[2]), .in_data2(in_data[2]), .in_full2(in_full[2]),
		.in_valid3(in_valid[3]), .in_ctl3(in_ctl[3]), .in_data3(in_data[3]), .in_full3(in_full[3]),
		.out_wr0(out_wr[0]), .out_ctl0(out_ctl[0]), .out_data0(out_data[0]),
		.out_wr1(out_wr[1]), .out_ctl1(out_ctl[1]), .out_data1(out_data[1]),
		.out_wr2(out_wr[2]), .out_ctl2(out_ctl[2]), .out_data2(out_data[2]),
		.out_wr3(out_wr[3]), .out_ctl3(out_ctl[3]), .out_data3(out_data[3])
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic bit model_busy();
		for (int p = 0; p < PORTS; p++) begin
			if (model_q[p].size() != 0) begin
				return 1'b1;
			end
		end
		return 1'b0;
	endfunction

	task automatic load_tests(output bit ok);
		int fd;
		int t;
		int arg;
		logic [PORTS-1:0] mask;
		logic [`XBAR_CTL_W-1:0] c [PORTS];
		logic [`XBAR_DATA_W-1:0] d [PORTS];
		logic [PORTS*CELL_W-1:0] cells;
		string line;
		ok = 1'b0;
		fd = $fopen(TEST_FILE, "r");
		if (fd == 0) begin
			return;
		end
		while ($fgets(line, fd) != 0) begin
			if (line.len() < 2 || line[0] == "#") begin
				continue;
			end
			if (line[0] == "V") begin
				if ($sscanf(line, "V %d %h %h %h %h %h %h %h %h %h", t, mask,
						c[0], d[0], c[1], d[1], c[2], d[2], c[3], d[3]) != 10) begin
					$fclose(fd);
					return;
				end
				for (int p = 0; p < PORTS; p++) begin
					cells[p*CELL_W +: CELL_W] = {c[p], d[p]};
				end
				vec_lines++;
			end else begin
				if ($sscanf(line.substr(2, line.len() - 1), "%d %d", t, arg) != 2) begin
					$fclose(fd);
					return;
				end
				mask = '0;
				cells = '0;
				n_tests++;
				if (line[0] == "R") begin
					rand_cycles += arg;
				end
			end
			rec_kind.push_back(line[0]);
			rec_test.push_back(t);
			rec_arg.push_back(arg);
			rec_mask.push_back(mask);
			rec_cells.push_back(cells);
		end
		$fclose(fd);
		ok = 1'b1;
	endtask

	task automatic report_mismatch(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		$display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
		test_errors++;
	endtask

	// outputs are stable at the falling edge
	task automatic check_outputs();
		for (int p = 0; p < PORTS; p++) begin
			assert (out_wr[p] === exp_wr[p])
				else report_mismatch($sformatf("out_wr%0d", p), out_wr[p], exp_wr[p]);
			assert (out_ctl[p] === exp_cell[p].ctl)
				else report_mismatch($sformatf("out_ctl%0d", p), out_ctl[p], exp_cell[p].ctl);
			assert (out_data[p] === exp_cell[p].data)
				else report_mismatch($sformatf("out_data%0d", p), out_data[p], exp_cell[p].data);
			assert (in_full[p] === (model_q[p].size() == DEPTH))
				else report_mismatch($sformatf("in_full%0d", p), in_full[p],
					model_q[p].size() == DEPTH);
			if (out_wr[p] === 1'b1) begin
				delivered++;
			end
		end
	endtask

	// one rising edge of the switch
	task automatic model_edge();
		logic [PORTS-1:0] taken;
		logic [PORTS-1:0] was_full;
		logic [PORTS-1:0] popped;
		logic [1:0] dst;
		crossbar_pkg::cell_t c;
		taken = '0;
		popped = '0;
		exp_wr = '0;
		for (int i = 0; i < PORTS; i++) begin
			was_full[i] = (model_q[i].size() == DEPTH);
			if (model_q[i].size() != 0) begin
				dst = model_q[i][0].ctl[1:0];
				if (!taken[dst]) begin
					taken[dst] = 1'b1;
					exp_wr[dst] = 1'b1;
					exp_cell[dst] = model_q[i][0];
					popped[i] = 1'b1;
				end
			end
		end
		for (int i = 0; i < PORTS; i++) begin
			if (popped[i]) begin
				void'(model_q[i].pop_front());
			end
			if (in_valid[i] && !was_full[i]) begin
				c.ctl = in_ctl[i];
				c.data = in_data[i];
				model_q[i].push_back(c);
				accepted++;
			end
		end
	endtask

	task automatic run_cycle(input logic [PORTS-1:0] mask, input logic [PORTS*CELL_W-1:0] cells);
		crossbar_pkg::cell_t c;
		@(negedge clk);
		check_outputs();
		for (int p = 0; p < PORTS; p++) begin
			c = cells[p*CELL_W +: CELL_W];
			in_valid[p] = mask[p];
			in_ctl[p] = c.ctl;
			in_data[p] = c.data;
		end
		@(posedge clk);
		model_edge();
	endtask

	// extra cycle lets the last delivery be checked
	task automatic drain_queues();
		while (model_busy()) begin
			run_cycle('0, '0);
		end
		run_cycle('0, '0);
	endtask

	task automatic run_random(input int cycles);
		logic [PORTS-1:0] mask;
		logic [PORTS*CELL_W-1:0] cells;
		crossbar_pkg::cell_t c;
		for (int n = 0; n < cycles; n++) begin
			for (int p = 0; p < PORTS; p++) begin
				rand_state = lcg_next(rand_state);
				mask[p] = rand_state[31];
				// source port and sequence number above the destination
				c.ctl = {seq_num[p], 2'(p), rand_state[30:29]};
				rand_state = lcg_next(rand_state);
				c.data = rand_state;
				cells[p*CELL_W +: CELL_W] = c;
				if (mask[p]) begin
					seq_num[p] = seq_num[p] + 1'b1;
				end
			end
			run_cycle(mask, cells);
		end
	endtask

	task automatic end_test(input int num, input int expected);
		assert (delivered == expected) else begin
			$display("test %0d delivered %0d cells where %0d were expected",
				num, delivered, expected);
			test_errors++;
		end
		if (test_errors == 0) begin
			tests_passed++;
		end else begin
			tests_failed++;
		end
		$display("test %0d %s: %0d cells delivered, %0d errors", num,
			(test_errors == 0) ? "ok" : "failed", delivered, test_errors);
		delivered = 0;
		accepted = 0;
		test_errors = 0;
	endtask

	initial begin
		wait (watch_limit != 0);
		#(watch_limit);
		$display("timeout: the run did not finish within %0d ns", watch_limit);
		$display("SOME TESTS FAILED");
		$finish;
	end

	initial begin
		rst = 1'b0;
		in_valid = '0;
		for (int p = 0; p < PORTS; p++) begin
			in_ctl[p] = '0;
			in_data[p] = '0;
			exp_cell[p] = '0;
			seq_num[p] = '0;
		end
		exp_wr = '0;
		load_tests(loaded);
		if (!loaded) begin
			$display("test vector file is missing or has a malformed line");
			$display("SOME TESTS FAILED");
			$finish;
		end else begin
			// four times the expected run, drains included
			watch_limit = longint'(vec_lines + rand_cycles + 5 + n_tests * (PORTS * DEPTH + 2))
				* 100 * 4;
			repeat (5) begin
				@(negedge clk);
				check_outputs();
			end
			rst = 1'b1;
			end_test(1, 0);
			for (int r = 0; r < rec_kind.size(); r++) begin
				case (rec_kind[r])
					"V": run_cycle(rec_mask[r], rec_cells[r]);
					"E": begin
						drain_queues();
						end_test(rec_test[r], rec_arg[r]);
					end
					default: begin
						run_random(rec_arg[r]);
						drain_queues();
						end_test(rec_test[r], accepted);
					end
				endcase
			end
			$display("%0d tests passed, %0d tests failed", tests_passed, tests_failed);
			if (tests_failed == 0) begin
				$display("ALL TESTS PASSED");
			end else begin
				$display("SOME TESTS FAILED");
			end
			$finish;
		end
	end

endmodule

// File: verif/crossbar_properties.sv
`timescale 1ns/1ps
`include "crossbar_config.svh"

module crossbar_properties (
	input logic clk,
	input logic rst,
	input logic [`XBAR_PORTS-1:0] out_wr,
	input logic [`XBAR_PORTS-1:0] in_full,
	input logic [`XBAR_PORTS-1:0] pop
);

	no_wr_in_reset: assert property (@(posedge clk) !rst |-> out_wr == '0)
		else $error("output strobe raised during reset");

	// a full queue only leaves full through a pop
	full_holds_without_pop: assert property (
		@(posedge clk) disable iff (!rst) ($past(in_full & ~pop) & ~in_full) == '0
	) else $error("in_full dropped without a pop");

	// each pop lands on an output of its own one cycle later
	one_strobe_per_pop: assert property (
		@(posedge clk) disable iff (!rst) $countones(out_wr) == $past($countones(pop))
	) else $error("strobe count differs from the pops of the previous cycle");

endmodule

bind crossbar crossbar_properties props0 (
	.clk(clk),
	.rst(rst),
	.out_wr(out_wr),
	.in_full(in_full),
	.pop(qif.pop)
);

// File: src/crossbar.sv
`timescale 1ns/1ps
`include "crossbar_config.svh"

module crossbar (
	input logic clk,
	input logic rst,

	input logic in_valid0,
	input logic [`XBAR_CTL_W-1:0] in_ctl0,
	input logic [`XBAR_DATA_W-1:0] in_data0,
	output logic in_full0,

	input logic in_valid1,
	input logic [`XBAR_CTL_W-1:0] in_ctl1,
	input logic [`XBAR_DATA_W-1:0] in_data1,
	output logic in_full1,

	input logic in_valid2,
	input logic [`XBAR_CTL_W-1:0] in_ctl2,
	input logic [`XBAR_DATA_W-1:0] in_data2,
	output logic in_full2,

	input logic in_valid3,
	input logic [`XBAR_CTL_W-1:0] in_ctl3,
	input logic [`XBAR_DATA_W-1:0] in_data3,
	output logic in_full3,

	output logic out_wr0,
	output logic [`XBAR_CTL_W-1:0] out_ctl0,
	output logic [`XBAR_DATA_W-1:0] out_data0,

	output logic out_wr1,
	output logic [`XBAR_CTL_W-1:0] out_ctl1,
	output logic [`XBAR_DATA_W-1:0] out_data1,

	output logic out_wr2,
	output logic [`XBAR_CTL_W-1:0] out_ctl2,
	output logic [`XBAR_DATA_W-1:0] out_data2,

	output logic out_wr3,
	output logic [`XBAR_CTL_W-1:0] out_ctl3,
	output logic [`XBAR_DATA_W-1:0] out_data3
);

	localparam int PORTS = `XBAR_PORTS;

	logic [PORTS-1:0] in_wr;
	crossbar_pkg::cell_t in_cell [PORTS];
	logic [PORTS-1:0] in_full;
	logic [PORTS-1:0] out_wr;
	crossbar_pkg::cell_t out_cell [PORTS];

	crossbar_queue_if qif ();

	// input side
	assign in_wr[0] = in_valid0;
	assign in_cell[0] = '{ctl: in_ctl0, data: in_data0};
	assign in_full0 = in_full[0];

	assign in_wr[1] = in_valid1;
	assign in_cell[1] = '{ctl: in_ctl1, data: in_data1};
	assign in_full1 = in_full[1];

	assign in_wr[2] = in_valid2;
	assign in_cell[2] = '{ctl: in_ctl2, data: in_data2};
	assign in_full2 = in_full[2];

	assign in_wr[3] = in_valid3;
	assign in_cell[3] = '{ctl: in_ctl3, data: in_data3};
	assign in_full3 = in_full[3];

	// output side
	assign out_wr0 = out_wr[0];
	assign out_ctl0 = out_cell[0].ctl;
	assign out_data0 = out_cell[0].data;

	assign out_wr1 = out_wr[1];
	assign out_ctl1 = out_cell[1].ctl;
	assign out_data1 = out_cell[1].data;

	assign out_wr2 = out_wr[2];
	assign out_ctl2 = out_cell[2].ctl;
	assign out_data2 = out_cell[2].data;

	assign out_wr3 = out_wr[3];
	assign out_ctl3 = out_cell[3].ctl;
	assign out_data3 = out_cell[3].data;

	// one queue per input
	for (genvar g = 0; g < PORTS; g++) begin : g_queue
		crossbar_in_queue #(
			.DEPTH(`XBAR_QUEUE_DEPTH),
			.IDX(g)
		) u_queue (
			.clk(clk),
			.rst(rst),
			.wr(in_wr[g]),
			.din(in_cell[g]),
			.full(in_full[g]),
			.q(qif.queue)
		);
	end

	crossbar_arbiter u_arbiter (
		.q(qif.arbiter)
	);

	crossbar_switch u_switch (
		.clk(clk),
		.rst(rst),
		.q(qif.switch),
		.out_wr(out_wr),
		.out_cell(out_cell)
	);

endmodule

// File: src/crossbar_switch.sv
`timescale 1ns/1ps
`include "crossbar_config.svh"

module crossbar_switch (
	input logic clk,
	input logic rst,
	crossbar_queue_if.switch q,
	output logic [`XBAR_PORTS-1:0] out_wr,
	output crossbar_pkg::cell_t out_cell [`XBAR_PORTS]
);

	localparam int PORTS = `XBAR_PORTS;

	logic [PORTS-1:0] hit;
	crossbar_pkg::cell_t sel [PORTS];

	// at most one popped input is granted each output
	always_comb begin
		for (int o = 0; o < PORTS; o++) begin
			hit[o] = 1'b0;
			sel[o] = '0;
			for (int i = 0; i < PORTS; i++) begin
				if (q.pop[i] && q.grant_dst[i] == crossbar_pkg::port_idx_t'(o)) begin
					hit[o] = 1'b1;
					sel[o] = q.head[i];
				end
			end
		end
	end

	// strobe lasts one cycle per delivered cell
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			out_wr <= '0;
		end else begin
			out_wr <= hit;
		end
	end

	// last cell held while the output is idle
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			for (int o = 0; o < PORTS; o++) begin
				out_cell[o] <= '0;
			end
		end else begin
			for (int o = 0; o < PORTS; o++) begin
				if (hit[o]) begin
					out_cell[o] <= sel[o];
				end
			end
		end
	end

endmodule

// File: src/crossbar_arbiter.sv
`timescale 1ns/1ps
`include "crossbar_config.svh"

module crossbar_arbiter (
	crossbar_queue_if.arbiter q
);

	localparam int PORTS = `XBAR_PORTS;
	localparam int IDX_W = $bits(crossbar_pkg::port_idx_t);

	crossbar_pkg::port_idx_t dst [PORTS];
	logic [PORTS-1:0] taken;

	// destination comes from the head cell and not the live input
	always_comb begin
		for (int i = 0; i < PORTS; i++) begin
			dst[i] = q.head[i].ctl[IDX_W-1:0];
		end
	end

	// fixed priority, input 0 first
	// a destination already taken blocks the input behind it
	always_comb begin
		taken = '0;
		for (int i = 0; i < PORTS; i++) begin
			q.pop[i] = 1'b0;
			q.grant_dst[i] = dst[i];
			if (!q.empty[i] && !taken[dst[i]]) begin
				taken[dst[i]] = 1'b1;
				q.pop[i] = 1'b1;
			end
		end
	end

endmodule

// File: src/crossbar_in_queue.sv
`timescale 1ns/1ps
`include "crossbar_config.svh"

module crossbar_in_queue #(
	parameter int DEPTH = `XBAR_QUEUE_DEPTH,
	parameter int IDX = 0
) (
	input logic clk,
	input logic rst,
	input logic wr,
	input crossbar_pkg::cell_t din,
	output logic full,
	crossbar_queue_if.queue q
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	crossbar_pkg::cell_t mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic push;
	logic pop;

	// wrap at DEPTH even when it is not a power of two
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	// writes into a full queue are lost
	assign push = wr && !full;
	assign pop = q.pop[IDX];

	assign full = (count == CNT_W'(DEPTH));
	assign q.empty[IDX] = (count == '0);

	// first word fall through
	assign q.head[IDX] = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= din;
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			wr_ptr <= '0;
		end else if (push) begin
			wr_ptr <= next_ptr(wr_ptr);
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			rd_ptr <= '0;
		end else if (pop) begin
			rd_ptr <= next_ptr(rd_ptr);
		end
	end

	// occupancy count
	// push and pop on one edge leave it unchanged
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			count <= '0;
		end else begin
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// File: src/crossbar_queue_if.sv
`timescale 1ns/1ps
`include "crossbar_config.svh"

interface crossbar_queue_if;

	// head cell per queue
	// only meaningful while empty is low
	crossbar_pkg::cell_t head [`XBAR_PORTS];
	logic [`XBAR_PORTS-1:0] empty;

	// arbiter decisions per input
	logic [`XBAR_PORTS-1:0] pop;
	crossbar_pkg::port_idx_t grant_dst [`XBAR_PORTS];

	// each queue drives its own index only
	modport queue (
		output head,
		output empty,
		input pop
	);

	modport arbiter (
		input head,
		input empty,
		output pop,
		output grant_dst
	);

	modport switch (
		input head,
		input pop,
		input grant_dst
	);

endinterface

// File: src/crossbar_pkg.sv
`include "crossbar_config.svh"

package crossbar_pkg;

	// port number and destination field of a control word
	typedef logic [$clog2(`XBAR_PORTS)-1:0] port_idx_t;

	typedef logic [`XBAR_CTL_W-1:0] ctl_t;

	typedef logic [`XBAR_DATA_W-1:0] data_t;

	// unit that is queued and switched
	typedef struct packed {
		ctl_t ctl;
		data_t data;
	} cell_t;

endpackage

// File: src/crossbar_config.svh
`ifndef CROSSBAR_CONFIG_SVH
`define CROSSBAR_CONFIG_SVH

// input and output ports
`define XBAR_PORTS 4

// payload word
`define XBAR_DATA_W 32

// control word
// low bits hold the destination port
// upper bits pass through untouched
`define XBAR_CTL_W 8

// cells held by each input queue
`define XBAR_QUEUE_DEPTH 4

`endif
